//--- Bender.yml
package:
  name: dcache

sources:
  - include_dirs:
      - src
    files:
      - src/dcache_pkg.sv
      - src/dcache_frames.sv
      - src/dcache_ctrl.sv
      - src/dcache_link.sv
      - src/dcache.sv
  - target: test
    files:
      - verification/dcache_mem_model.sv
      - verification/tb_dcache.sv

//--- dcache.f
+incdir+src
src/dcache_pkg.sv
src/dcache_frames.sv
src/dcache_ctrl.sv
src/dcache_link.sv
src/dcache.sv
verification/dcache_mem_model.sv
verification/tb_dcache.sv

//--- src/dcache.sv
/*
 * 2-way write-back data cache
 * joins frame storage, controller and link register
 */

`timescale 1ns/1ns
`default_nettype none

`include "dcache_config.svh"

module dcache import dcache_pkg::*;
(
    input  logic     CLK,
    input  logic     nRST,
    input  cpu_req_t req,
    output cpu_rsp_t rsp,
    output mem_req_t mem_req,
    input  mem_rsp_t mem_rsp
);

    frame_upd_t                      upd;
    logic                            hit;
    logic                            hit_way;
    word_t                           hit_data;
    logic                            victim_way;
    logic                            victim_dirty;
    logic [`DCACHE_TAG_W-1:0]        victim_tag;
    word_t [`DCACHE_BLOCK_WORDS-1:0] victim_data;
    dcache_frame_t                   flush_frame;
    logic [`DCACHE_IDX_W-1:0]        flush_idx;
    logic                            flush_way;
    logic                            flush_word;
    logic                            sc_ok;
    logic                            sc_fail;
    logic                            write_commit;

    dcache_frames i_frames
    (
        .CLK          (CLK),
        .nRST         (nRST),
        .lookup_addr  (dcache_addr_t'(req.dmemaddr)),
        .upd          (upd),
        .flush_idx    (flush_idx),
        .flush_way    (flush_way),
        .flush_word   (flush_word),
        .hit          (hit),
        .hit_way      (hit_way),
        .hit_data     (hit_data),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .victim_data  (victim_data),
        .flush_frame  (flush_frame)
    );

    dcache_ctrl i_ctrl
    (
        .CLK          (CLK),
        .nRST         (nRST),
        .req          (req),
        .mem_rsp      (mem_rsp),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .victim_data  (victim_data),
        .flush_frame  (flush_frame),
        .sc_fail      (sc_fail),
        .mem_req      (mem_req),
        .upd          (upd),
        .flush_idx    (flush_idx),
        .flush_way    (flush_way),
        .flush_word   (flush_word),
        .dhit         (rsp.dhit),
        .flushed      (rsp.flushed),
        .write_commit (write_commit)
    );

    dcache_link i_link
    (
        .CLK          (CLK),
        .nRST         (nRST),
        .req          (req),
        .write_commit (write_commit),
        .sc_ok        (sc_ok),
        .sc_fail      (sc_fail)
    );

    // store-conditional reports success, everything else the hit word
    assign rsp.dmemload = (req.datomic && req.dmemWEN) ? word_t'(sc_ok) : hit_data;

endmodule

`default_nettype wire

//--- src/dcache_config.svh
/*
 * data cache geometry
 * word width, set count, ways and block size of the write-back cache
 */

`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// data and address width
`define DCACHE_WORD_W 32

// 8 sets, indexed by 3 address bits
`define DCACHE_SETS 8
`define DCACHE_IDX_W 3

// 2-way, two words per block
`define DCACHE_WAYS 2
`define DCACHE_BLOCK_WORDS 2

// word width minus index, word offset and byte offset
`define DCACHE_TAG_W 26

`endif

//--- src/dcache_ctrl.sv
/*
 * data cache controller
 * miss handling with writeback and refill, store sequencing and halt flush
 */

`timescale 1ns/1ns
`default_nettype none

`include "dcache_config.svh"

module dcache_ctrl import dcache_pkg::*;
(
    input  logic                            CLK,
    input  logic                            nRST,
    input  cpu_req_t                        req,
    input  mem_rsp_t                        mem_rsp,
    input  logic                            hit,
    input  logic                            hit_way,
    input  logic                            victim_way,
    input  logic                            victim_dirty,
    input  logic [`DCACHE_TAG_W-1:0]        victim_tag,
    input  word_t [`DCACHE_BLOCK_WORDS-1:0] victim_data,
    input  dcache_frame_t                   flush_frame,
    input  logic                            sc_fail,
    output mem_req_t                        mem_req,
    output frame_upd_t                      upd,
    output logic [`DCACHE_IDX_W-1:0]        flush_idx,
    output logic                            flush_way,
    output logic                            flush_word,
    output logic                            dhit,
    output logic                            flushed,
    output logic                            write_commit
);

    typedef enum logic [2:0]
    {
        IDLE, WBACK, FILL, WRITE, DONE, FLUSH, FLUSHED
    } state_t;

    state_t state, next_state;

    dcache_addr_t addr;
    logic         blk_cnt;
    logic [`DCACHE_IDX_W+1:0] walk_cnt;
    logic         blk_step;
    logic         walk_step;
    logic         slot_dirty;
    logic         sc_drop;

    assign addr = dcache_addr_t'(req.dmemaddr);

    // walk order is word, then set, then way
    assign {flush_way, flush_idx, flush_word} = walk_cnt;

    assign slot_dirty = flush_frame.valid && flush_frame.dirty;
    assign sc_drop    = req.datomic && req.dmemWEN && sc_fail;
    assign blk_step   = ((state == WBACK) || (state == FILL)) && !mem_rsp.dwait;
    assign walk_step  = (state == FLUSH) && (!slot_dirty || !mem_rsp.dwait);
    assign flushed    = (state == FLUSHED);

    ////////////////////
    // state and counters
    ////////////////////

    always_ff @(posedge CLK, negedge nRST)
    begin
        if (!nRST)
        begin
            state    <= IDLE;
            blk_cnt  <= 1'b0;
            walk_cnt <= '0;
        end
        else
        begin
            state <= next_state;
            if (blk_step)
            begin
                blk_cnt <= ~blk_cnt;
            end
            if (walk_step)
            begin
                walk_cnt <= walk_cnt + 1'b1;
            end
        end
    end

    always_comb
    begin
        next_state = state;
        unique case (state)
            IDLE:
            begin
                if (req.halt)
                begin
                    next_state = FLUSH;
                end
                else if ((req.dmemREN || req.dmemWEN) && !sc_drop)
                begin
                    if (!hit)
                    begin
                        next_state = victim_dirty ? WBACK : FILL;
                    end
                    else if (req.dmemWEN)
                    begin
                        next_state = WRITE;
                    end
                end
            end
            WBACK:
            begin
                if (blk_step && blk_cnt)
                begin
                    next_state = FILL;
                end
            end
            FILL:
            begin
                // reads go back and hit, writes go on to the store
                if (blk_step && blk_cnt)
                begin
                    next_state = req.dmemWEN ? WRITE : IDLE;
                end
            end
            WRITE:   next_state = DONE;
            DONE:    next_state = IDLE;
            FLUSH:
            begin
                if (walk_step && (&walk_cnt))
                begin
                    next_state = FLUSHED;
                end
            end
            FLUSHED: next_state = FLUSHED;
            default: next_state = IDLE;
        endcase
    end

    ////////////////////
    // outputs
    ////////////////////

    always_comb
    begin
        mem_req       = '0;
        mem_req.daddr = {addr.tag, addr.idx, 1'b0, 2'b00};
        upd           = '0;
        dhit          = 1'b0;
        write_commit  = 1'b0;
        unique case (state)
            IDLE:
            begin
                if (!req.halt && sc_drop)
                begin
                    // failed store-conditional answers at once
                    dhit = 1'b1;
                end
                else if (!req.halt && req.dmemREN && hit)
                begin
                    dhit     = 1'b1;
                    upd.touch = 1'b1;
                    upd.way   = hit_way;
                end
            end
            WBACK:
            begin
                mem_req.dWEN   = 1'b1;
                mem_req.daddr  = {victim_tag, addr.idx, blk_cnt, 2'b00};
                mem_req.dstore = victim_data[blk_cnt];
            end
            FILL:
            begin
                mem_req.dREN  = 1'b1;
                mem_req.daddr = {addr.tag, addr.idx, blk_cnt, 2'b00};
                if (!mem_rsp.dwait)
                begin
                    upd.fill_word = 1'b1;
                    upd.fill_done = blk_cnt;
                    upd.way       = victim_way;
                    upd.fill_pos  = blk_cnt;
                    upd.data      = mem_rsp.dload;
                end
            end
            WRITE:
            begin
                upd.write_word = 1'b1;
                upd.touch      = 1'b1;
                upd.way        = hit_way;
                upd.data       = req.dmemstore;
            end
            DONE:
            begin
                dhit         = 1'b1;
                write_commit = 1'b1;
            end
            FLUSH:
            begin
                // clean and invalid slots are skipped in one cycle
                if (slot_dirty)
                begin
                    mem_req.dWEN   = 1'b1;
                    mem_req.daddr  = {flush_frame.tag, flush_idx, flush_word, 2'b00};
                    mem_req.dstore = flush_frame.data[flush_word];
                    if (!mem_rsp.dwait)
                    begin
                        upd.clean = 1'b1;
                        upd.way   = flush_way;
                    end
                end
            end
            default:
            begin
            end
        endcase
    end

endmodule

`default_nettype wire

//--- src/dcache_frames.sv
/*
 * cache frame storage
 * two ways of eight frames, tag compare, mru bits and frame updates
 */

`timescale 1ns/1ns
`default_nettype none

`include "dcache_config.svh"

module dcache_frames import dcache_pkg::*;
(
    input  logic                            CLK,
    input  logic                            nRST,
    input  dcache_addr_t                    lookup_addr,
    input  frame_upd_t                      upd,
    input  logic [`DCACHE_IDX_W-1:0]        flush_idx,
    input  logic                            flush_way,
    input  logic                            flush_word,
    output logic                            hit,
    output logic                            hit_way,
    output word_t                           hit_data,
    output logic                            victim_way,
    output logic                            victim_dirty,
    output logic [`DCACHE_TAG_W-1:0]        victim_tag,
    output word_t [`DCACHE_BLOCK_WORDS-1:0] victim_data,
    output dcache_frame_t                   flush_frame
);

    dcache_frame_t frames [`DCACHE_WAYS][`DCACHE_SETS];

    // way last used in each set
    logic [`DCACHE_SETS-1:0] mru;

    logic [`DCACHE_WAYS-1:0] way_match;
    dcache_frame_t           victim_frame;
    logic [`DCACHE_IDX_W-1:0] idx;

    assign idx = lookup_addr.idx;

    ////////////////////
    // lookup
    ////////////////////

    always_comb
    begin
        for (int w = 0; w < `DCACHE_WAYS; w++)
        begin
            way_match[w] = frames[w][idx].valid && (frames[w][idx].tag == lookup_addr.tag);
        end
    end

    assign hit      = |way_match;
    assign hit_way  = way_match[1];
    assign hit_data = frames[hit_way][idx].data[lookup_addr.blkoff];

    // an empty way is taken before the lru one
    always_comb
    begin
        if (!frames[0][idx].valid)
        begin
            victim_way = 1'b0;
        end
        else if (!frames[1][idx].valid)
        begin
            victim_way = 1'b1;
        end
        else
        begin
            victim_way = ~mru[idx];
        end
    end

    assign victim_frame = frames[victim_way][idx];
    assign victim_dirty = victim_frame.valid && victim_frame.dirty;
    assign victim_tag   = victim_frame.tag;
    assign victim_data  = victim_frame.data;

    // frame under the flush walk
    assign flush_frame = frames[flush_way][flush_idx];

    ////////////////////
    // updates
    ////////////////////

    always_ff @(posedge CLK, negedge nRST)
    begin
        if (!nRST)
        begin
            for (int w = 0; w < `DCACHE_WAYS; w++)
            begin
                for (int s = 0; s < `DCACHE_SETS; s++)
                begin
                    frames[w][s].valid <= 1'b0;
                    frames[w][s].dirty <= 1'b0;
                end
            end
            mru <= '0;
        end
        else
        begin
            // one fetched word per memory beat
            if (upd.fill_word)
            begin
                frames[upd.way][idx].data[upd.fill_pos] <= upd.data;
            end
            if (upd.fill_done)
            begin
                frames[upd.way][idx].tag   <= lookup_addr.tag;
                frames[upd.way][idx].valid <= 1'b1;
                frames[upd.way][idx].dirty <= 1'b0;
            end
            if (upd.write_word)
            begin
                frames[upd.way][idx].data[lookup_addr.blkoff] <= upd.data;
                frames[upd.way][idx].dirty <= 1'b1;
            end
            // frame stays dirty until its last word has gone out
            if (upd.clean && flush_word)
            begin
                frames[upd.way][flush_idx].dirty <= 1'b0;
            end
            if (upd.touch)
            begin
                mru[idx] <= upd.way;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/dcache_link.sv
/*
 * link register
 * tracks the load-linked address for store-conditional
 */

`timescale 1ns/1ns
`default_nettype none

module dcache_link import dcache_pkg::*;
(
    input  logic     CLK,
    input  logic     nRST,
    input  cpu_req_t req,
    input  logic     write_commit,
    output logic     sc_ok,
    output logic     sc_fail
);

    word_t link_addr;
    logic  link_valid;
    logic  ll_req;

    assign ll_req = req.datomic && req.dmemREN;

    // request address still covered by the link
    assign sc_ok   = link_valid && (req.dmemaddr == link_addr);
    assign sc_fail = req.datomic && req.dmemWEN && !sc_ok;

    always_ff @(posedge CLK, negedge nRST)
    begin
        if (!nRST)
        begin
            link_valid <= 1'b0;
        end
        else if (ll_req)
        begin
            link_valid <= 1'b1;
        end
        else if (write_commit && sc_ok)
        begin
            // any store to the linked word breaks the link
            link_valid <= 1'b0;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (ll_req)
        begin
            link_addr <= req.dmemaddr;
        end
    end

endmodule

`default_nettype wire

//--- src/dcache_pkg.sv
/*
 * data cache types
 * address split, frame layout and the datapath and memory port bundles
 */

`default_nettype none

`include "dcache_config.svh"

package dcache_pkg;

    typedef logic [`DCACHE_WORD_W-1:0] word_t;

    // one decode of the request address
    typedef struct packed {
        logic [`DCACHE_TAG_W-1:0] tag;
        logic [`DCACHE_IDX_W-1:0] idx;
        logic                     blkoff;
        logic [1:0]               bytoff;
    } dcache_addr_t;

    typedef struct packed {
        logic                               valid;
        logic                               dirty;
        logic [`DCACHE_TAG_W-1:0]           tag;
        word_t [`DCACHE_BLOCK_WORDS-1:0]    data;
    } dcache_frame_t;

    ////////////////////
    // datapath side
    ////////////////////

    typedef struct packed {
        logic  dmemREN;
        logic  dmemWEN;
        logic  datomic;
        logic  halt;
        word_t dmemaddr;
        word_t dmemstore;
    } cpu_req_t;

    typedef struct packed {
        logic  dhit;
        word_t dmemload;
        logic  flushed;
    } cpu_rsp_t;

    ////////////////////
    // memory side
    ////////////////////

    typedef struct packed {
        logic  dREN;
        logic  dWEN;
        word_t daddr;
        word_t dstore;
    } mem_req_t;

    typedef struct packed {
        logic  dwait;
        word_t dload;
    } mem_rsp_t;

    // frame update strobes from the controller
    typedef struct packed {
        logic  fill_word;
        logic  fill_done;
        logic  write_word;
        logic  clean;
        logic  touch;
        logic  way;
        logic  fill_pos;
        word_t data;
    } frame_upd_t;

endpackage

`default_nettype wire

//--- verification/dcache_mem_model.sv
/*
 * memory behind the data cache port
 * word-addressed storage with random wait states
 */

`timescale 1ns/1ns
`default_nettype none

module dcache_mem_model import dcache_pkg::*;
#(
    parameter int DEPTH_W = 8
)
(
    input  logic     CLK,
    input  logic     nRST,
    input  mem_req_t mem_req,
    output mem_rsp_t mem_rsp
);

    word_t              mem [2**DEPTH_W];
    logic               stall;
    logic               active;
    logic [DEPTH_W-1:0] widx;

    assign widx          = mem_req.daddr[DEPTH_W+1:2];
    assign active        = mem_req.dREN || mem_req.dWEN;
    assign mem_rsp.dwait = !active || stall;
    assign mem_rsp.dload = mem[widx];

    // start contents follow the word address
    initial
    begin
        for (int i = 0; i < 2**DEPTH_W; i++)
        begin
            mem[i] = {8'(i), 8'(~i), 8'(i * 7), 8'(i ^ 8'h5a)};
        end
    end

    // roughly one cycle in three is a wait state
    always_ff @(posedge CLK, negedge nRST)
    begin
        if (!nRST)
        begin
            stall <= 1'b1;
        end
        else
        begin
            stall <= ($urandom_range(0, 2) == 0);
        end
    end

    always @(posedge CLK)
    begin
        if (mem_req.dWEN && !mem_rsp.dwait)
        begin
            mem[widx] <= mem_req.dstore;
        end
    end

endmodule

`default_nettype wire

//--- verification/tb_dcache.sv
/*
 * testbench for the 2-way data cache
 * directed and random accesses checked against a memory and link model
 */

`timescale 1ns/1ns
`default_nettype none

module tb_dcache import dcache_pkg::*;
();

    localparam int NUM_OPS     = 300;
    localparam int NUM_RANDOM  = 256;
    localparam int CYCLE_LIMIT = NUM_OPS * 40 + 200;
    localparam int MEM_WORDS   = 256;

    logic     CLK;
    logic     nRST;
    cpu_req_t req;
    cpu_rsp_t rsp;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;

    // reference view of memory and the link register
    word_t model_mem [MEM_WORDS];
    logic  link_valid;
    word_t link_addr;

    int cycles;
    int checks;
    int errors;
    int test_errors;

    dcache i_dcache
    (
        .CLK     (CLK),
        .nRST    (nRST),
        .req     (req),
        .rsp     (rsp),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    dcache_mem_model #(.DEPTH_W(8)) i_mem_model
    (
        .CLK     (CLK),
        .nRST    (nRST),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    always #2 CLK = ~CLK;

    always @(posedge CLK)
    begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("timeout: the cache stopped answering within %0d cycles", CYCLE_LIMIT);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    ////////////////////
    // helpers
    ////////////////////

    task automatic compare_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic end_test(input string name);
        $display("test %-18s done, %0d errors", name, errors - test_errors);
        test_errors = errors;
    endtask

    function automatic int word_index(input word_t addr);
        return int'(addr[9:2]);
    endfunction

    function automatic word_t make_addr(input int tag, input int idx, input int blkoff);
        dcache_addr_t a;
        a          = '0;
        a.tag[3:0] = 4'(tag);
        a.idx      = 3'(idx);
        a.blkoff   = 1'(blkoff);
        return word_t'(a);
    endfunction

    // five tags over sets 1, 3, 5 and 7
    function automatic word_t pick_addr();
        return make_addr($urandom_range(0, 4), 2 * $urandom_range(0, 3) + 1,
                         $urandom_range(0, 1));
    endfunction

    // one request held until dhit, sampled on the falling edge
    task automatic access(input logic ren, input logic wen, input logic atomic,
                          input word_t addr, input word_t data, output word_t load);
        cpu_req_t r;
        r           = '0;
        r.dmemREN   = ren;
        r.dmemWEN   = wen;
        r.datomic   = atomic;
        r.dmemaddr  = addr;
        r.dmemstore = data;
        @(posedge CLK);
        req <= r;
        @(negedge CLK);
        while (!rsp.dhit)
        begin
            @(negedge CLK);
        end
        load = rsp.dmemload;
    endtask

    task automatic read_word(input word_t addr, input logic atomic);
        word_t load;
        access(1'b1, 1'b0, atomic, addr, '0, load);
        compare_word($sformatf("dmemload @%h", addr), load, model_mem[word_index(addr)]);
        if (atomic)
        begin
            link_valid = 1'b1;
            link_addr  = addr;
        end
    endtask

    task automatic write_word(input word_t addr, input word_t data);
        word_t load;
        access(1'b0, 1'b1, 1'b0, addr, data, load);
        model_mem[word_index(addr)] = data;
        // a store to the linked word breaks the link
        if (link_valid && (addr == link_addr))
        begin
            link_valid = 1'b0;
        end
    endtask

    task automatic store_conditional(input word_t addr, input word_t data);
        word_t load;
        logic  ok;
        ok = link_valid && (addr == link_addr);
        access(1'b0, 1'b1, 1'b1, addr, data, load);
        compare_word($sformatf("sc result @%h", addr), load, word_t'(ok));
        if (ok)
        begin
            model_mem[word_index(addr)] = data;
            link_valid                  = 1'b0;
        end
    endtask

    ////////////////////
    // tests
    ////////////////////

    task automatic random_ops(input int count);
        int    kind;
        word_t addr;
        for (int n = 0; n < count; n++)
        begin
            kind = $urandom_range(0, 99);
            addr = pick_addr();
            if (kind < 40)
            begin
                read_word(addr, 1'b0);
            end
            else if (kind < 75)
            begin
                write_word(addr, $urandom());
            end
            else if (kind < 88)
            begin
                read_word(addr, 1'b1);
            end
            else
            begin
                // most store-conditionals go to the live link
                if (link_valid && ($urandom_range(0, 3) != 0))
                begin
                    addr = link_addr;
                end
                store_conditional(addr, $urandom());
            end
        end
    endtask

    task automatic flush_all();
        cpu_req_t r;
        r      = '0;
        r.halt = 1'b1;
        @(posedge CLK);
        req <= r;
        @(negedge CLK);
        while (!rsp.flushed)
        begin
            @(negedge CLK);
        end
        repeat (8)
        begin
            @(negedge CLK);
            compare_word("flushed", word_t'(rsp.flushed), 32'd1);
        end
        for (int k = 0; k < MEM_WORDS; k++)
        begin
            compare_word($sformatf("mem[%0d]", k), i_mem_model.mem[k], model_mem[k]);
        end
    endtask

    initial
    begin
        word_t a;
        void'($urandom(32'hc0d0));
        CLK         = 1'b0;
        nRST        = 1'b0;
        req         = '0;
        link_valid  = 1'b0;
        link_addr   = '0;
        cycles      = 0;
        checks      = 0;
        errors      = 0;
        test_errors = 0;
        repeat (10) @(posedge CLK);
        nRST <= 1'b1;
        for (int k = 0; k < MEM_WORDS; k++)
        begin
            model_mem[k] = i_mem_model.mem[k];
        end
        @(negedge CLK);
        compare_word("dhit", word_t'(rsp.dhit), '0);
        compare_word("flushed", word_t'(rsp.flushed), '0);
        compare_word("dREN", word_t'(mem_req.dREN), '0);
        compare_word("dWEN", word_t'(mem_req.dWEN), '0);
        end_test("reset");

        for (int n = 0; n < 4; n++)
        begin
            a = pick_addr();
            write_word(a, $urandom());
            read_word(a, 1'b0);
        end
        end_test("read_after_write");

        // four tags in set 6 overflow both ways
        for (int t = 1; t <= 4; t++)
        begin
            write_word(make_addr(t, 6, 0), $urandom());
            write_word(make_addr(t, 6, 1), $urandom());
        end
        for (int t = 1; t <= 4; t++)
        begin
            read_word(make_addr(t, 6, 0), 1'b0);
            read_word(make_addr(t, 6, 1), 1'b0);
        end
        end_test("set_conflict");

        a = make_addr(2, 2, 1);
        read_word(a, 1'b1);
        store_conditional(a, 32'h5c5c_0001);
        read_word(a, 1'b0);
        read_word(a, 1'b1);
        write_word(a, 32'h0000_beef);
        store_conditional(a, 32'h5c5c_0002);
        read_word(a, 1'b0);
        end_test("ll_sc");

        random_ops(NUM_RANDOM);
        end_test("random_ops");

        flush_all();
        end_test("flush");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
        begin
            $display("STATUS: PASS");
        end
        else
        begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
